// ==== sources.f ====
design/oramPkg.sv
design/harnessPkg.sv
design/uartReceiver.sv
design/packetAssembler.sv
design/commandBuffer.sv
design/burstGate.sv
design/hwTestHarness.sv
tests/clockGen.sv
tests/hwTestHarnessTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module hwTestHarnessTb \
	-f sources.f \
	-o simHarness
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/simHarness
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0

// ==== tests/hwTestHarnessTb.sv ====
/*
 * Directed tests of the serial ORAM test harness, ClocksPerBit 16, FIFO depth 8.
 * Stops at the first mismatch; the overflow test runs last since the flag is sticky.
 */
module hwTestHarnessTb import harnessPkg::*, oramPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ClocksPerBit = 16;
	localparam int BufferDepth  = 8;
	localparam int PacketCycles = PacketBytes * 10 * ClocksPerBit;
	localparam int HoldCycles   = 2000;
	localparam int StallCycles  = 300;
	localparam int SettleCycles = 50;
	// Packets sent over all tests, Start markers included
	localparam int TotalPackets = 23;
	// Hold, delays of the delay test, stall, settling and reset
	localparam int WaitCycles = HoldCycles + 250 + StallCycles + 10 * SettleCycles + 16;
	localparam int TimeoutCycles = (TotalPackets * PacketCycles + WaitCycles) * 3 / 2;

	// One observed transfer on the ORAM port
	typedef struct packed {
		oramRequest_t request;
		logic         active;
		int unsigned  cycle;
	} transfer_t;

	logic         Clock;
	logic         reset;
	logic         uartRx;
	logic         oramReady;
	oramRequest_t oramRequest;
	logic         oramValid;
	logic         burstActive;
	logic         bufferOverflow;

	transfer_t    transfers[$];
	testPacket_t  expectedQ[$];
	int unsigned  cycleCount = 0;

	clockGen i_clockGen (
		.Clock(Clock),
		.reset(reset)
	);

	hwTestHarness #(
		.ClocksPerBit(ClocksPerBit),
		.BufferDepth (BufferDepth)
	) i_hwTestHarness (
		.Clock         (Clock),
		.reset         (reset),
		.uartRx        (uartRx),
		.oramReady     (oramReady),
		.oramRequest   (oramRequest),
		.oramValid     (oramValid),
		.burstActive   (burstActive),
		.bufferOverflow(bufferOverflow)
	);

	// --------------------------------------------------
	// Port monitor and run limit
	// --------------------------------------------------

	always @(posedge Clock) begin
		transfer_t rec;
		cycleCount++;
		if (!reset && oramValid && oramReady) begin
			rec.request = oramRequest;
			rec.active = burstActive;
			rec.cycle = cycleCount;
			transfers.push_back(rec);
		end
		if (cycleCount >= TimeoutCycles) begin
			$display("STATUS: FAIL");
			$fatal(1, "Timeout: tests still running after %0d cycles", TimeoutCycles);
		end
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------

	task automatic checkValue(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("FAIL at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// One 8N1 frame, LSB first, called on a falling edge
	task automatic sendByte(input uartByte_t data);
		uartRx = 1'b0;
		repeat (ClocksPerBit) @(negedge Clock);
		for (int i = 0; i < UartDataBits; i++) begin
			uartRx = data[i];
			repeat (ClocksPerBit) @(negedge Clock);
		end
		uartRx = 1'b1;
		repeat (ClocksPerBit) @(negedge Clock);
	endtask

	// Most significant byte first
	task automatic sendPacket(input testPacket_t pkt);
		for (int i = PacketBytes - 1; i >= 0; i--) begin
			sendByte(pkt[i*8 +: 8]);
		end
	endtask

	task automatic sendCommand(input testCommand_t cmd, input timeDelay_t delay,
			input bit queued);
		testPacket_t pkt;
		pkt.command = cmd;
		pkt.pAddr = $urandom();
		pkt.timeDelay = delay;
		// Dropped packets are not expected at the port
		if (queued) begin
			expectedQ.push_back(pkt);
		end
		sendPacket(pkt);
	endtask

	task automatic sendStart();
		testPacket_t pkt;
		pkt.command = CmdStart;
		pkt.pAddr = $urandom();
		pkt.timeDelay = '0;
		sendPacket(pkt);
	endtask

	task automatic clearRecords();
		transfers.delete();
		expectedQ.delete();
	endtask

	// Waits for count transfers, then checks order, payload and gate close
	task automatic checkBurst(input int count);
		testPacket_t exp;
		while (transfers.size() < count) @(negedge Clock);
		repeat (SettleCycles) @(negedge Clock);
		checkValue("transfer count", 64'(transfers.size()), 64'(count));
		for (int i = 0; i < count; i++) begin
			exp = expectedQ[i];
			// Operation is the low two bits of the command byte
			checkValue("oramRequest.command", 64'(transfers[i].request.command),
				64'(exp.command[1:0]));
			checkValue("oramRequest.pAddr", 64'(transfers[i].request.pAddr), 64'(exp.pAddr));
		end
		checkValue("burstActive after burst", 64'(burstActive), 64'(0));
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------

	task automatic heldWithoutStart();
		sendCommand(CmdUpdate, 16'd4, 1'b1);
		sendCommand(CmdRead, 16'd0, 1'b1);
		sendCommand(CmdReadRemove, 16'd9, 1'b1);
		repeat (HoldCycles) @(negedge Clock);
		checkValue("transfers before Start", 64'(transfers.size()), 64'(0));
		checkValue("burstActive", 64'(burstActive), 64'(0));
		checkValue("bufferOverflow", 64'(bufferOverflow), 64'(0));
	endtask

	// Releases the three commands left by the previous test
	task automatic burstRelease();
		sendStart();
		checkBurst(3);
		checkValue("burstActive at first transfer", 64'(transfers[0].active), 64'(1));
	endtask

	task automatic timeDelays();
		int unsigned gap;
		timeDelay_t  delay;
		sendCommand(CmdAppend, 16'd0, 1'b1);
		sendCommand(CmdRead, 16'd50, 1'b1);
		sendCommand(CmdUpdate, 16'd200, 1'b1);
		sendStart();
		checkBurst(3);
		for (int i = 1; i < 3; i++) begin
			gap = transfers[i].cycle - transfers[i-1].cycle;
			delay = expectedQ[i].timeDelay;
			checkValue($sformatf("gap %0d covers delay %0d", gap, delay),
				64'(gap >= delay), 64'(1));
		end
	endtask

	task automatic backPressure();
		oramRequest_t held;
		sendCommand(CmdReadRemove, 16'd0, 1'b1);
		sendCommand(CmdAppend, 16'd3, 1'b1);
		sendCommand(CmdRead, 16'd7, 1'b1);
		oramReady = 1'b0;
		sendStart();
		while (!oramValid) @(negedge Clock);
		held = oramRequest;
		// The stalled request is the first command queued
		checkValue("oramRequest.pAddr at stall", 64'(held.pAddr), 64'(expectedQ[0].pAddr));
		repeat (StallCycles) begin
			@(negedge Clock);
			checkValue("oramValid during stall", 64'(oramValid), 64'(1));
			checkValue("oramRequest during stall", 64'(oramRequest), 64'(held));
		end
		oramReady = 1'b1;
		checkBurst(3);
	endtask

	// Two writes past the depth are dropped
	task automatic overflowDrop();
		for (int i = 0; i < BufferDepth + 2; i++) begin
			sendCommand(testCommand_t'(i % 4), 16'd0, i < BufferDepth);
		end
		repeat (SettleCycles) @(negedge Clock);
		checkValue("bufferOverflow", 64'(bufferOverflow), 64'(1));
		checkValue("burstActive before Start", 64'(burstActive), 64'(0));
		sendStart();
		checkBurst(BufferDepth);
	endtask

	initial begin
		void'($urandom(20436));
		uartRx = 1'b1;
		oramReady = 1'b1;
		@(negedge Clock);
		while (reset) @(negedge Clock);
		repeat (SettleCycles) @(negedge Clock);
		heldWithoutStart();
		burstRelease();
		clearRecords();
		timeDelays();
		clearRecords();
		backPressure();
		clearRecords();
		overflowDrop();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== tests/clockGen.sv ====
/*
 * Free-running 100 ns clock for the testbench.
 * Reset is held high for 16 cycles and released on a falling edge.
 */
module clockGen (
	output logic Clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HalfPeriod  = 50;
	localparam int ResetCycles = 16;

	initial begin
		Clock = 1'b0;
		forever #HalfPeriod Clock = ~Clock;
	end

	// Release away from the active edge
	initial begin
		reset = 1'b1;
		repeat (ResetCycles) @(posedge Clock);
		@(negedge Clock);
		reset = 1'b0;
	end

endmodule

// ==== design/hwTestHarness.sv ====
/*
 * Serial-driven test harness for the ORAM backend, single clock.
 * Serial input has no flow control; see bufferOverflow.
 */
module hwTestHarness import harnessPkg::*, oramPkg::*; #(
	parameter int ClocksPerBit = 16,
	parameter int BufferDepth  = 8
) (
	input  logic         Clock,
	input  logic         reset,
	input  logic         uartRx,
	input  logic         oramReady,
	output oramRequest_t oramRequest,
	output logic         oramValid,
	output logic         burstActive,
	output logic         bufferOverflow
);

	uartByte_t   rxByte;
	logic        rxValid;
	testPacket_t packet;
	logic        packetValid;
	testPacket_t headPacket;
	logic        headValid;
	logic        headReady;

	// --------------------------------------------------
	// Serial front end
	// --------------------------------------------------

	uartReceiver #(
		.ClocksPerBit(ClocksPerBit)
	) i_uartReceiver (
		.Clock  (Clock),
		.reset  (reset),
		.uartRx (uartRx),
		.rxByte (rxByte),
		.rxValid(rxValid)
	);

	packetAssembler i_packetAssembler (
		.Clock      (Clock),
		.reset      (reset),
		.rxByte     (rxByte),
		.rxValid    (rxValid),
		.packet     (packet),
		.packetValid(packetValid)
	);

	// --------------------------------------------------
	// Queue and issue
	// --------------------------------------------------

	// Both see every packet, each picks its own kind
	commandBuffer #(
		.BufferDepth(BufferDepth)
	) i_commandBuffer (
		.Clock         (Clock),
		.reset         (reset),
		.packet        (packet),
		.packetValid   (packetValid),
		.headPacket    (headPacket),
		.headValid     (headValid),
		.headReady     (headReady),
		.bufferOverflow(bufferOverflow)
	);

	burstGate i_burstGate (
		.Clock      (Clock),
		.reset      (reset),
		.packet     (packet),
		.packetValid(packetValid),
		.headPacket (headPacket),
		.headValid  (headValid),
		.headReady  (headReady),
		.oramRequest(oramRequest),
		.oramValid  (oramValid),
		.oramReady  (oramReady),
		.burstActive(burstActive)
	);

endmodule

// ==== design/burstGate.sv ====
/*
 * Holds queued commands until Start, then issues each after its own delay.
 * The gate closes whenever the FIFO runs dry; later commands need a new Start.
 */
module burstGate import harnessPkg::*, oramPkg::*; (
	input  logic         Clock,
	input  logic         reset,
	input  testPacket_t  packet,
	input  logic         packetValid,
	input  testPacket_t  headPacket,
	input  logic         headValid,
	output logic         headReady,
	output oramRequest_t oramRequest,
	output logic         oramValid,
	input  logic         oramReady,
	output logic         burstActive
);

	logic         startGate;
	logic         startSeen;
	logic         outFull;
	oramRequest_t outRequest;
	timeDelay_t   outDelay;
	timeDelay_t   age;
	logic         delayMet;
	logic         transfer;
	logic         load;

	// --------------------------------------------------
	// Start gate
	// --------------------------------------------------

	assign startSeen = packetValid && (packet.command == CmdStart);

	// Start wins over a same-cycle close
	always_ff @(posedge Clock) begin
		if (reset) begin
			startGate <= 1'b0;
		end else if (startSeen) begin
			startGate <= 1'b1;
		end else if (startGate && !headValid) begin
			startGate <= 1'b0;
		end
	end

	assign burstActive = startGate;

	// --------------------------------------------------
	// Output register
	// --------------------------------------------------

	assign delayMet = age >= outDelay;
	assign oramValid = outFull && delayMet;
	assign transfer = oramValid && oramReady;

	// Accept when empty or emptying this cycle
	assign headReady = startGate && (!outFull || transfer);
	assign load = headReady && headValid;

	always_ff @(posedge Clock) begin
		if (reset) begin
			outFull <= 1'b0;
		end else if (load) begin
			outFull <= 1'b1;
		end else if (transfer) begin
			outFull <= 1'b0;
		end
	end

	// Payload, low command bits select the backend operation
	always_ff @(posedge Clock) begin
		if (load) begin
			outRequest.command <= oramCommand_t'(headPacket.command[1:0]);
			outRequest.pAddr <= headPacket.pAddr;
			outDelay <= headPacket.timeDelay;
		end
	end

	assign oramRequest = outRequest;

	// --------------------------------------------------
	// Age counter
	// --------------------------------------------------

	// Saturates once the delay is met so a long stall cannot wrap it
	always_ff @(posedge Clock) begin
		if (reset) begin
			age <= '0;
		end else if (load) begin
			age <= '0;
		end else if (outFull && !delayMet) begin
			age <= age + 1'b1;
		end
	end

	// Stalled request holds steady until taken
	assert property (@(posedge Clock) disable iff (reset)
		(oramValid && !oramReady) |=> (oramValid && $stable(oramRequest)));

endmodule

// ==== design/commandBuffer.sv ====
/*
 * Command FIFO with first-word fall-through head. BufferDepth is a power of two.
 * Start packets are never stored; writes to a full FIFO are dropped.
 */
module commandBuffer import harnessPkg::*; #(
	parameter int BufferDepth = 8
) (
	input  logic        Clock,
	input  logic        reset,
	input  testPacket_t packet,
	input  logic        packetValid,
	output testPacket_t headPacket,
	output logic        headValid,
	input  logic        headReady,
	output logic        bufferOverflow
);

	localparam int AddrWidth = $clog2(BufferDepth);

	testPacket_t          mem [BufferDepth];
	logic [AddrWidth-1:0] wrPtr;
	logic [AddrWidth-1:0] rdPtr;
	logic [AddrWidth:0]   count;
	logic                 full;
	logic                 writeRequest;
	logic                 doWrite;
	logic                 doPop;

	// Only commands go in
	assign writeRequest = packetValid && (packet.command != CmdStart);
	assign full = count == (AddrWidth + 1)'(BufferDepth);
	assign doWrite = writeRequest && !full;
	assign doPop = headValid && headReady;

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------

	always_ff @(posedge Clock) begin
		if (doWrite) begin
			mem[wrPtr] <= packet;
		end
	end

	assign headPacket = mem[rdPtr];
	assign headValid = count != '0;

	// --------------------------------------------------
	// Pointers and occupancy
	// --------------------------------------------------

	// Pointers wrap naturally at the power-of-two depth
	always_ff @(posedge Clock) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			bufferOverflow <= 1'b0;
		end else begin
			if (doWrite) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			count <= count + doWrite - doPop;
			// Sticky until reset
			if (writeRequest && full) begin
				bufferOverflow <= 1'b1;
			end
		end
	end

	// Occupancy never wraps below empty or above full
	assert property (@(posedge Clock) disable iff (reset)
		count <= (AddrWidth + 1)'(BufferDepth));

endmodule

// ==== design/packetAssembler.sv ====
/*
 * Collects seven bytes, MSB first, into one test packet.
 * No framing resync: a lost byte shifts every later packet.
 */
module packetAssembler import harnessPkg::*; (
	input  logic        Clock,
	input  logic        reset,
	input  uartByte_t   rxByte,
	input  logic        rxValid,
	output testPacket_t packet,
	output logic        packetValid
);

	localparam int CountWidth = $clog2(PacketBytes);
	localparam int ByteBits   = $bits(uartByte_t);

	logic [PacketBits-1:0] shiftReg;
	logic [CountWidth-1:0] byteCount;
	logic                  lastByte;

	// --------------------------------------------------
	// Byte shifting
	// --------------------------------------------------

	// Earlier bytes move toward the MSB end
	always_ff @(posedge Clock) begin
		if (rxValid) begin
			shiftReg <= {shiftReg[PacketBits-ByteBits-1:0], rxByte};
		end
	end

	assign lastByte = byteCount == CountWidth'(PacketBytes - 1);

	// --------------------------------------------------
	// Packet boundary
	// --------------------------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			byteCount <= '0;
			packetValid <= 1'b0;
		end else begin
			packetValid <= 1'b0;
			if (rxValid) begin
				if (lastByte) begin
					byteCount <= '0;
					// Shift register is complete next cycle
					packetValid <= 1'b1;
				end else begin
					byteCount <= byteCount + 1'b1;
				end
			end
		end
	end

	// Held until the next byte lands
	assign packet = testPacket_t'(shiftReg);

endmodule

// ==== design/uartReceiver.sv ====
/*
 * 8N1 receiver sampling each bit at mid-period. ClocksPerBit must be 4 or more.
 * Frames with a low stop bit are dropped without any error indication.
 */
module uartReceiver import harnessPkg::*; #(
	parameter int ClocksPerBit = 16
) (
	input  logic      Clock,
	input  logic      reset,
	input  logic      uartRx,
	output uartByte_t rxByte,
	output logic      rxValid
);

	localparam int TimerWidth    = $clog2(ClocksPerBit);
	localparam int BitCountWidth = $clog2(UartDataBits);

	typedef enum logic [1:0] {Idle, StartBit, DataBits, StopBit} rxState_e;

	rxState_e                 state;
	logic [1:0]               rxSync;
	logic                     rxLine;
	logic [TimerWidth-1:0]    bitTimer;
	logic [BitCountWidth-1:0] bitCount;
	uartByte_t                shiftReg;
	logic                     midStart;
	logic                     bitEnd;

	// Two-stage synchronizer, line idles high
	always_ff @(posedge Clock) begin
		if (reset) begin
			rxSync <= 2'b11;
		end else begin
			rxSync <= {rxSync[0], uartRx};
		end
	end

	assign rxLine = rxSync[1];

	// Half a bit into the start bit
	assign midStart = bitTimer == TimerWidth'(ClocksPerBit / 2 - 1);
	// Full bit period after the last sample point
	assign bitEnd = bitTimer == TimerWidth'(ClocksPerBit - 1);

	// --------------------------------------------------
	// Frame FSM
	// --------------------------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			state <= Idle;
			bitTimer <= '0;
			bitCount <= '0;
			rxValid <= 1'b0;
		end else begin
			rxValid <= 1'b0;
			bitTimer <= bitTimer + 1'b1;
			case (state)
				Idle: begin
					bitTimer <= '0;
					if (!rxLine) begin
						state <= StartBit;
					end
				end
				StartBit: begin
					if (midStart) begin
						bitTimer <= '0;
						bitCount <= '0;
						// Glitch shorter than half a bit
						state <= rxLine ? Idle : DataBits;
					end
				end
				DataBits: begin
					if (bitEnd) begin
						bitTimer <= '0;
						bitCount <= bitCount + 1'b1;
						if (bitCount == BitCountWidth'(UartDataBits - 1)) begin
							state <= StopBit;
						end
					end
				end
				StopBit: begin
					if (bitEnd) begin
						// Strobe only on a valid stop bit
						rxValid <= rxLine;
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge Clock) begin
		if (state == DataBits && bitEnd) begin
			shiftReg <= {rxLine, shiftReg[UartDataBits-1:1]};
		end
	end

	assign rxByte = shiftReg;

	// Frames are at least ten bit periods apart
	assert property (@(posedge Clock) disable iff (reset) rxValid |=> !rxValid);

endmodule

// ==== design/harnessPkg.sv ====
/*
 * Host test packet format and serial framing.
 * A packet is 56 bits and crosses the line MSB first as seven 8N1 bytes.
 */
package harnessPkg;

	// --------------------------------------------------
	// Serial framing
	// --------------------------------------------------

	typedef logic [7:0] uartByte_t;

	// Data bits per frame, LSB first on the line
	localparam int UartDataBits = 8;

	// --------------------------------------------------
	// Test packet
	// --------------------------------------------------

	typedef logic [7:0] testCommand_t;

	// Low two bits of the ORAM codes give the backend operation
	typedef enum testCommand_t {
		CmdUpdate     = 8'd0,
		CmdAppend     = 8'd1,
		CmdRead       = 8'd2,
		CmdReadRemove = 8'd3,
		CmdStart      = 8'hFF
	} testCommandCode_e;

	// Cycles a command waits in the output stage
	typedef logic [15:0] timeDelay_t;

	typedef struct packed {
		testCommand_t       command;
		oramPkg::physAddr_t pAddr;
		timeDelay_t         timeDelay;
	} testPacket_t;

	localparam int PacketBits  = $bits(testPacket_t);
	localparam int PacketBytes = 7;

endpackage

// ==== design/oramPkg.sv ====
/*
 * Command and request types seen by the ORAM backend port.
 * The operation encoding matches the low two bits of a test command byte.
 */
package oramPkg;

	// --------------------------------------------------
	// Backend operations
	// --------------------------------------------------

	typedef enum logic [1:0] {
		OramUpdate     = 2'd0,
		OramAppend     = 2'd1,
		OramRead       = 2'd2,
		OramReadRemove = 2'd3
	} oramCommand_t;

	// Physical block address
	typedef logic [31:0] physAddr_t;

	// One request on the valid/ready port
	typedef struct packed {
		oramCommand_t command;
		physAddr_t    pAddr;
	} oramRequest_t;

endpackage
